/* Bender.yml */
package:
  name: rv_core

sources:
  - logic/rv_pkg.sv
  - logic/reg_file.sv
  - logic/fetch_stage.sv
  - logic/decode_stage.sv
  - logic/execute_stage.sv
  - logic/memory_stage.sv
  - logic/rv_core.sv
  - target: test
    files:
      - tb/rv_core_checker.sv
      - tb/rv_core_tb.sv

/* logic/decode_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module decode_stage (
    input  rv_pkg::if_id_t     if_id,
    input  rv_pkg::reg_write_t id_ex_busy,
    input  rv_pkg::reg_write_t ex_mem_busy,
    output rv_pkg::reg_addr_t  rs1,
    output rv_pkg::reg_addr_t  rs2,
    input  rv_pkg::word_t      rdata1,
    input  rv_pkg::word_t      rdata2,
    output rv_pkg::id_ex_t     id_ex,
    output logic               stall_front
);
    import rv_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      inst;
    op_e        op;
    word_t      imm;
    logic       use_rs1;
    logic       use_rs2;
    logic       hit1;
    logic       hit2;

    function automatic logic pending(reg_addr_t rs, reg_write_t busy);
        return busy.enable && busy.rd == rs;
    endfunction

    assign inst   = if_id.inst;
    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];

    always_comb begin
        op = op_nop;
        case (opcode)
            7'b0110011: begin
                case ({funct7, funct3})
                    10'b0000000_000: op = op_add;
                    10'b0100000_000: op = op_sub;
                    10'b0000000_111: op = op_and;
                    10'b0000000_110: op = op_or;
                    10'b0000000_100: op = op_xor;
                    default:         op = op_nop;
                endcase
            end
            7'b0010011: if (funct3 == 3'b000) op = op_addi;
            7'b0110111: op = op_lui;
            7'b0000011: if (funct3 == 3'b010) op = op_lw;
            7'b0100011: if (funct3 == 3'b010) op = op_sw;
            7'b1100011: if (funct3 == 3'b000) op = op_beq;
            default:    op = op_nop;
        endcase
    end

    // immediate formats
    always_comb begin
        case (op)
            op_addi, op_lw: imm = {{20{inst[31]}}, inst[31:20]};
            op_sw:          imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            op_beq:         imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
                                   inst[11:8], 1'b0};
            op_lui:         imm = {inst[31:12], 12'b0};
            default:        imm = '0;
        endcase
    end

    assign use_rs1 = op inside {op_add, op_sub, op_and, op_or, op_xor, op_addi,
                                op_lw, op_sw, op_beq};
    assign use_rs2 = op inside {op_add, op_sub, op_and, op_or, op_xor, op_sw, op_beq};

    // interlock on results still in execute or memory
    assign hit1 = use_rs1 && rs1 != '0 &&
                  (pending(rs1, id_ex_busy) || pending(rs1, ex_mem_busy));
    assign hit2 = use_rs2 && rs2 != '0 &&
                  (pending(rs2, id_ex_busy) || pending(rs2, ex_mem_busy));

    assign stall_front = if_id.valid && (hit1 || hit2);

    always_comb begin
        id_ex.valid = if_id.valid && !stall_front;
        id_ex.pc    = if_id.pc;
        id_ex.inst  = inst;
        id_ex.op    = op;
        id_ex.rd    = inst[11:7];
        id_ex.opa   = rdata1;
        id_ex.opb   = rdata2;
        id_ex.imm   = imm;
    end

endmodule

`default_nettype wire

/* logic/execute_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module execute_stage (
    input  rv_pkg::id_ex_t  id_ex,
    output rv_pkg::ex_mem_t ex_mem,
    output rv_pkg::jump_t   jump,
    output logic            ok
);
    import rv_pkg::*;

    word_t result;
    logic  equal;

    always_comb begin
        case (id_ex.op)
            op_add:  result = id_ex.opa + id_ex.opb;
            op_sub:  result = id_ex.opa - id_ex.opb;
            op_and:  result = id_ex.opa & id_ex.opb;
            op_or:   result = id_ex.opa | id_ex.opb;
            op_xor:  result = id_ex.opa ^ id_ex.opb;
            op_addi: result = id_ex.opa + id_ex.imm;
            op_lui:  result = id_ex.imm;
            // effective address
            op_lw,
            op_sw:   result = id_ex.opa + id_ex.imm;
            default: result = '0;
        endcase
    end

    assign equal = (id_ex.opa == id_ex.opb);

    // taken beq redirects fetch
    always_comb begin
        jump.valid  = id_ex.valid && id_ex.op == op_beq && equal;
        jump.target = id_ex.pc + id_ex.imm;
    end

    always_comb begin
        ex_mem.valid      = id_ex.valid;
        ex_mem.pc         = id_ex.pc;
        ex_mem.inst       = id_ex.inst;
        ex_mem.op         = id_ex.op;
        ex_mem.rd         = id_ex.rd;
        ex_mem.result     = result;
        ex_mem.store_data = id_ex.opb;
    end

    // single-cycle ALU
    assign ok = 1'b1;

endmodule

`default_nettype wire

/* logic/fetch_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_stage (
    input  logic               clk,
    input  logic               rst,
    input  logic               enable,
    input  rv_pkg::jump_t      jump,
    input  logic               hold,
    output rv_pkg::ibus_req_t  ireq,
    input  rv_pkg::ibus_resp_t iresp,
    output rv_pkg::if_id_t     if_id,
    output logic               ok
);
    import rv_pkg::*;

    bus_state_e state;
    addr_t      pc;
    logic       buf_valid;
    word_t      buf_inst;
    logic       move;

    assign ireq.valid = (state == bus_wait);
    assign ireq.addr  = pc;

    assign ok   = buf_valid || (state == bus_wait && iresp.data_ok);
    // a redirect overrides the decode stall
    assign move = enable && (!hold || jump.valid);

    assign if_id.valid = ok && !jump.valid;
    assign if_id.pc    = pc;
    assign if_id.inst  = buf_valid ? buf_inst : iresp.data;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= bus_idle;
            pc        <= RESET_PC;
            buf_valid <= 1'b0;
        end else begin
            case (state)
                bus_idle: if (move || !buf_valid) state <= bus_wait;
                bus_wait: if (iresp.data_ok && !move) state <= bus_idle;
                default:  state <= bus_idle;
            endcase
            if (move) begin
                pc        <= jump.valid ? jump.target : pc + 32'd4;
                buf_valid <= 1'b0;
            end else if (state == bus_wait && iresp.data_ok) begin
                buf_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == bus_wait && iresp.data_ok) begin
            buf_inst <= iresp.data;
        end
    end

endmodule

`default_nettype wire

/* logic/memory_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module memory_stage (
    input  logic               clk,
    input  logic               rst,
    input  rv_pkg::ex_mem_t    ex_mem,
    output rv_pkg::dbus_req_t  dreq,
    input  rv_pkg::dbus_resp_t dresp,
    output rv_pkg::mem_wb_t    mem_wb,
    output logic               ok
);
    import rv_pkg::*;

    bus_state_e state;
    logic       is_mem;
    logic       held;
    logic       fire;
    logic       done;
    addr_t      done_pc;
    word_t      load_data;
    word_t      load_value;

    assign is_mem = ex_mem.valid && (ex_mem.op == op_lw || ex_mem.op == op_sw);
    // access already finished and slot not yet moved on
    assign held   = done && done_pc == ex_mem.pc;

    assign dreq.valid = (state == bus_wait) || (is_mem && !held);
    assign dreq.write = (ex_mem.op == op_sw);
    assign dreq.addr  = ex_mem.result;
    assign dreq.wdata = ex_mem.store_data;

    assign fire = dreq.valid && dresp.data_ok;
    assign ok   = !is_mem || held || fire;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= bus_idle;
            done  <= 1'b0;
        end else begin
            state <= (dreq.valid && !dresp.data_ok) ? bus_wait : bus_idle;
            if (fire) done <= 1'b1;
            else if (!held) done <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            done_pc   <= ex_mem.pc;
            load_data <= dresp.rdata;
        end
    end

    assign load_value = held ? load_data : dresp.rdata;

    always_comb begin
        mem_wb.valid            = ex_mem.valid;
        mem_wb.pc               = ex_mem.pc;
        mem_wb.inst             = ex_mem.inst;
        mem_wb.reg_write.enable = ex_mem.valid && writes_rd(ex_mem.op);
        mem_wb.reg_write.rd     = ex_mem.rd;
        mem_wb.reg_write.data   = (ex_mem.op == op_lw) ? load_value : ex_mem.result;
    end

endmodule

`default_nettype wire

/* logic/reg_file.sv */
`timescale 1ns/1ns
`default_nettype none

module reg_file (
    input  logic               clk,
    input  logic               rst,
    input  rv_pkg::reg_write_t wr,
    input  rv_pkg::reg_addr_t  rs1,
    input  rv_pkg::reg_addr_t  rs2,
    output rv_pkg::word_t      rdata1,
    output rv_pkg::word_t      rdata2
);
    import rv_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.enable && wr.rd != '0) begin
            regs[wr.rd] <= wr.data;
        end
    end

    // write-through so decode sees the retiring value
    assign rdata1 = (rs1 == '0) ? '0 :
                    (wr.enable && wr.rd == rs1) ? wr.data : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 :
                    (wr.enable && wr.rd == rs2) ? wr.data : regs[rs2];

endmodule

`default_nettype wire

/* logic/rv_core.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_core (
    input  logic               clk,
    input  logic               rst,
    output rv_pkg::ibus_req_t  ireq,
    input  rv_pkg::ibus_resp_t iresp,
    output rv_pkg::dbus_req_t  dreq,
    input  rv_pkg::dbus_resp_t dresp,
    output rv_pkg::commit_t    commit
);
    import rv_pkg::*;

    if_id_t     if_id_q, if_id_d;
    id_ex_t     id_ex_q, id_ex_d;
    ex_mem_t    ex_mem_q, ex_mem_d;
    mem_wb_t    mem_wb_q, mem_wb_d;

    logic       fetch_ok;
    logic       execute_ok;
    logic       memory_ok;
    logic       all_ok;
    logic       stall_front;
    jump_t      jump;
    reg_addr_t  rs1, rs2;
    word_t      rdata1, rdata2;
    reg_write_t wb;
    reg_write_t id_ex_busy;
    reg_write_t ex_mem_busy;

    // decode is combinational and never stalls the pipe
    assign all_ok = fetch_ok & execute_ok & memory_ok;

    always_comb begin
        wb.enable = mem_wb_q.valid && mem_wb_q.reg_write.enable && all_ok;
        wb.rd     = mem_wb_q.reg_write.rd;
        wb.data   = mem_wb_q.reg_write.data;

        commit.valid     = mem_wb_q.valid && all_ok;
        commit.pc        = mem_wb_q.pc;
        commit.inst      = mem_wb_q.inst;
        commit.reg_write = wb;
    end

    // destinations still in flight for the decode interlock
    always_comb begin
        id_ex_busy.enable  = id_ex_q.valid && writes_rd(id_ex_q.op);
        id_ex_busy.rd      = id_ex_q.rd;
        id_ex_busy.data    = '0;
        ex_mem_busy.enable = ex_mem_q.valid && writes_rd(ex_mem_q.op);
        ex_mem_busy.rd     = ex_mem_q.rd;
        ex_mem_busy.data   = ex_mem_q.result;
    end

    reg_file i_reg_file (
        .clk, .rst, .wr(wb), .rs1, .rs2, .rdata1, .rdata2
    );

    fetch_stage i_fetch (
        .clk, .rst, .enable(all_ok), .jump, .hold(stall_front),
        .ireq, .iresp, .if_id(if_id_d), .ok(fetch_ok)
    );

    decode_stage i_decode (
        .if_id(if_id_q), .id_ex_busy, .ex_mem_busy, .rs1, .rs2,
        .rdata1, .rdata2, .id_ex(id_ex_d), .stall_front
    );

    execute_stage i_execute (
        .id_ex(id_ex_q), .ex_mem(ex_mem_d), .jump, .ok(execute_ok)
    );

    memory_stage i_memory (
        .clk, .rst, .ex_mem(ex_mem_q), .dreq, .dresp, .mem_wb(mem_wb_d), .ok(memory_ok)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            if_id_q  <= '0;
            id_ex_q  <= '0;
            ex_mem_q <= '0;
            mem_wb_q <= '0;
        end else if (all_ok) begin
            // hold the front on a stall unless a redirect flushes it
            if (jump.valid || !stall_front) begin
                if_id_q <= if_id_d;
            end
            id_ex_q  <= jump.valid ? '0 : id_ex_d;
            ex_mem_q <= ex_mem_d;
            mem_wb_q <= mem_wb_d;
        end
    end

endmodule

`default_nettype wire

/* logic/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [XLEN-1:0] addr_t;
    typedef logic [4:0]      reg_addr_t;

    localparam addr_t RESET_PC = '0;

    typedef enum logic [3:0] {
        op_nop,
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_addi,
        op_lui,
        op_lw,
        op_sw,
        op_beq
    } op_e;

    // request state shared by both bus users
    typedef enum logic {
        bus_idle,
        bus_wait
    } bus_state_e;

    typedef struct packed {
        logic  valid;
        addr_t addr;
    } ibus_req_t;

    typedef struct packed {
        logic  data_ok;
        word_t data;
    } ibus_resp_t;

    typedef struct packed {
        logic  valid;
        logic  write;
        addr_t addr;
        word_t wdata;
    } dbus_req_t;

    typedef struct packed {
        logic  data_ok;
        word_t rdata;
    } dbus_resp_t;

    typedef struct packed {
        logic      enable;
        reg_addr_t rd;
        word_t     data;
    } reg_write_t;

    typedef struct packed {
        logic  valid;
        addr_t target;
    } jump_t;

    typedef struct packed {
        logic  valid;
        addr_t pc;
        word_t inst;
    } if_id_t;

    typedef struct packed {
        logic      valid;
        addr_t     pc;
        word_t     inst;
        op_e       op;
        reg_addr_t rd;
        word_t     opa;
        word_t     opb;
        word_t     imm;
    } id_ex_t;

    typedef struct packed {
        logic      valid;
        addr_t     pc;
        word_t     inst;
        op_e       op;
        reg_addr_t rd;
        word_t     result;
        word_t     store_data;
    } ex_mem_t;

    typedef struct packed {
        logic       valid;
        addr_t      pc;
        word_t      inst;
        reg_write_t reg_write;
    } mem_wb_t;

    // retirement record
    typedef struct packed {
        logic       valid;
        addr_t      pc;
        word_t      inst;
        reg_write_t reg_write;
    } commit_t;

    // ops that produce a register result
    function automatic logic writes_rd(op_e op);
        return op inside {op_add, op_sub, op_and, op_or, op_xor, op_addi, op_lui, op_lw};
    endfunction

endpackage

`default_nettype wire

/* rv_core.f */
logic/rv_pkg.sv
logic/reg_file.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/rv_core.sv
tb/rv_core_checker.sv
tb/rv_core_tb.sv

/* tb/rv_core_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_core_checker (
    input logic               clk,
    input logic               rst,
    input rv_pkg::ibus_req_t  ireq,
    input rv_pkg::ibus_resp_t iresp,
    input rv_pkg::dbus_req_t  dreq,
    input rv_pkg::dbus_resp_t dresp,
    input rv_pkg::commit_t    commit
);

    int unsigned errors = 0;

    // request fields held until the response arrives
    ireq_stable: assert property (@(posedge clk) disable iff (rst)
        ireq.valid && !iresp.data_ok |=> $stable(ireq))
        else begin
            errors++;
            $error("instruction request changed before data_ok");
        end

    dreq_stable: assert property (@(posedge clk) disable iff (rst)
        dreq.valid && !dresp.data_ok |=> $stable(dreq))
        else begin
            errors++;
            $error("data request changed before data_ok");
        end

    quiet_in_reset: assert property (@(posedge clk)
        rst |-> !commit.valid && !ireq.valid && !dreq.valid)
        else begin
            errors++;
            $error("bus request or retirement during reset");
        end

    commit_known: assert property (@(posedge clk) disable iff (rst)
        commit.valid |-> !$isunknown(commit))
        else begin
            errors++;
            $error("retire record holds unknown bits");
        end

endmodule

`default_nettype wire

/* tb/rv_core_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_core_tb;
    import rv_pkg::*;

    localparam int    N_INST   = 200;
    localparam int    SEED     = 930;
    localparam int    TIMEOUT  = N_INST * 4 * 4 + 100;
    localparam addr_t FINAL_PC = addr_t'((N_INST - 1) * 4);

    logic       clk;
    logic       rst;
    ibus_req_t  ireq;
    ibus_resp_t iresp;
    dbus_req_t  dreq;
    dbus_resp_t dresp;
    commit_t    commit;

    word_t   rom [256];
    word_t   ram [64];
    word_t   m_regs [32];
    word_t   m_ram [64];
    addr_t   m_pc;
    logic    i_busy;
    logic    d_busy;
    int      i_delay;
    int      d_delay;
    int      cycle;
    int      n_commits;
    logic    finished;
    commit_t expected;

    rv_core i_dut (.clk, .rst, .ireq, .iresp, .dreq, .dresp, .commit);

    bind rv_core rv_core_checker i_checker (
        .clk(clk), .rst(rst), .ireq(ireq), .iresp(iresp),
        .dreq(dreq), .dresp(dresp), .commit(commit)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic word_t r_type(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                     logic [2:0] f3, reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic word_t i_type(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                     reg_addr_t rd, logic [6:0] opcode);
        return {imm, rs1, f3, rd, opcode};
    endfunction

    function automatic word_t s_type(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t b_type(logic [12:0] off, reg_addr_t rs2, reg_addr_t rs1);
        return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic word_t ram_fill(int i);
        return (32'(i) * 32'h9e37_79b9) ^ 32'h1357_0000;
    endfunction

    function automatic string commit_text(commit_t c);
        return $sformatf("{valid=%0b pc=%h inst=%h we=%0b rd=%0d data=%h}", c.valid, c.pc,
                         c.inst, c.reg_write.enable, c.reg_write.rd, c.reg_write.data);
    endfunction

    // rd and data mean nothing without a write
    function automatic commit_t masked_commit(commit_t c);
        commit_t m;
        m = c;
        if (!c.reg_write.enable) begin
            m.reg_write.rd   = '0;
            m.reg_write.data = '0;
        end
        return m;
    endfunction

    task automatic fail_with(string line);
        $display("%s", line);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_commit(string name, commit_t exp, commit_t act);
        if (masked_commit(act) !== masked_commit(exp)) begin
            fail_with($sformatf("Mismatch %s: expected %s, actual %s", name,
                                commit_text(exp), commit_text(act)));
        end
    endtask

    task automatic check_word(string name, word_t exp, word_t act);
        if (act !== exp) begin
            fail_with($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic build_program();
        int          sel;
        int          span;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        logic [11:0] offset;
        for (int k = 0; k < N_INST - 1; k++) begin
            sel    = $urandom_range(99, 0);
            rd     = reg_addr_t'($urandom_range(7, 0));
            rs1    = reg_addr_t'($urandom_range(7, 0));
            rs2    = reg_addr_t'($urandom_range(7, 0));
            offset = 12'($urandom_range(63, 0) * 4);
            if (sel < 10) begin
                rom[k] = r_type(7'b0000000, rs2, rs1, 3'b000, rd);
            end else if (sel < 18) begin
                rom[k] = r_type(7'b0100000, rs2, rs1, 3'b000, rd);
            end else if (sel < 26) begin
                rom[k] = r_type(7'b0000000, rs2, rs1, 3'b111, rd);
            end else if (sel < 34) begin
                rom[k] = r_type(7'b0000000, rs2, rs1, 3'b110, rd);
            end else if (sel < 42) begin
                rom[k] = r_type(7'b0000000, rs2, rs1, 3'b100, rd);
            end else if (sel < 56) begin
                rom[k] = i_type(12'($urandom_range(4095, 0)), rs1, 3'b000, rd, 7'b0010011);
            end else if (sel < 62) begin
                rom[k] = {20'($urandom), rd, 7'b0110111};
            end else if (sel < 75) begin
                rom[k] = i_type(offset, 5'd0, 3'b010, rd, 7'b0000011);
            end else if (sel < 88) begin
                rom[k] = s_type(offset, rs2, 5'd0);
            end else begin
                // forward only and never past the final loop
                span = N_INST - 1 - k;
                if (span > 8) begin
                    span = 8;
                end
                if (sel < 94) begin
                    rs2 = rs1;
                end
                rom[k] = b_type(13'($urandom_range(span, 1) * 4), rs2, rs1);
            end
        end
        rom[N_INST - 1] = b_type(13'd0, 5'd0, 5'd0);
        // filler addi into x0 past the program
        for (int k = N_INST; k < 256; k++) begin
            rom[k] = i_type(12'(k), 5'd0, 3'b000, 5'd0, 7'b0010011);
        end
    endtask

    // one architectural step of the reference model
    task automatic step_model(output commit_t exp);
        word_t     inst;
        word_t     a;
        word_t     b;
        word_t     value;
        word_t     imm_i;
        word_t     imm_b;
        addr_t     ld_addr;
        addr_t     st_addr;
        addr_t     next_pc;
        reg_addr_t rd;
        logic      wen;
        inst    = rom[m_pc[9:2]];
        rd      = inst[11:7];
        a       = m_regs[inst[19:15]];
        b       = m_regs[inst[24:20]];
        imm_i   = {{20{inst[31]}}, inst[31:20]};
        imm_b   = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        ld_addr = a + imm_i;
        st_addr = a + {{20{inst[31]}}, inst[31:25], inst[11:7]};
        next_pc = m_pc + 32'd4;
        wen     = 1'b0;
        value   = '0;
        case (inst[6:0])
            7'b0110011: begin
                wen = 1'b1;
                case ({inst[31:25], inst[14:12]})
                    10'b0000000_000: value = a + b;
                    10'b0100000_000: value = a - b;
                    10'b0000000_111: value = a & b;
                    10'b0000000_110: value = a | b;
                    10'b0000000_100: value = a ^ b;
                    default:         wen = 1'b0;
                endcase
            end
            7'b0010011: begin
                wen   = (inst[14:12] == 3'b000);
                value = a + imm_i;
            end
            7'b0110111: begin
                wen   = 1'b1;
                value = {inst[31:12], 12'b0};
            end
            7'b0000011: begin
                wen   = (inst[14:12] == 3'b010);
                value = m_ram[ld_addr[7:2]];
            end
            7'b0100011: begin
                if (inst[14:12] == 3'b010) begin
                    m_ram[st_addr[7:2]] = b;
                end
            end
            7'b1100011: begin
                if (inst[14:12] == 3'b000 && a == b) begin
                    next_pc = m_pc + imm_b;
                end
            end
            default: wen = 1'b0;
        endcase
        exp.valid            = 1'b1;
        exp.pc               = m_pc;
        exp.inst             = inst;
        exp.reg_write.enable = wen;
        exp.reg_write.rd     = rd;
        exp.reg_write.data   = value;
        if (wen && rd != '0) begin
            m_regs[rd] = value;
        end
        m_pc = next_pc;
    endtask

    task automatic sample_outputs();
        if (i_dut.i_checker.errors != 0) begin
            fail_with("Error: an assertion on the bus handshake or retire port failed");
        end
        if (cycle == 1) begin
            if (!ireq.valid) begin
                fail_with("Error: no instruction request in the first cycle after reset");
            end else begin
                check_word("first fetch address", RESET_PC, ireq.addr);
            end
        end
        if (ireq.valid && iresp.data_ok) begin
            i_busy = 1'b0;
        end
        if (dreq.valid && dresp.data_ok) begin
            d_busy = 1'b0;
            if (dreq.write) begin
                ram[dreq.addr[7:2]] = dreq.wdata;
            end
        end
        if (commit.valid) begin
            step_model(expected);
            check_commit($sformatf("random program commit %0d", n_commits), expected, commit);
            n_commits++;
            finished = (expected.pc == FINAL_PC);
        end
        cycle++;
        if (cycle > TIMEOUT) begin
            fail_with($sformatf("Error: final loop not reached within %0d cycles", TIMEOUT));
        end
    endtask

    // bus models with 0 to 3 cycles of latency
    task automatic drive_responses();
        iresp.data_ok = 1'b0;
        dresp.data_ok = 1'b0;
        if (ireq.valid) begin
            if (!i_busy) begin
                i_busy  = 1'b1;
                i_delay = $urandom_range(3, 0);
            end
            if (i_delay == 0) begin
                iresp.data_ok = 1'b1;
                iresp.data    = rom[ireq.addr[9:2]];
            end else begin
                i_delay--;
            end
        end
        if (dreq.valid) begin
            if (dreq.addr > 32'd252 || dreq.addr[1:0] != 2'b00) begin
                fail_with("Error: data access outside the 64-word RAM");
            end
            if (!d_busy) begin
                d_busy  = 1'b1;
                d_delay = $urandom_range(3, 0);
            end
            if (d_delay == 0) begin
                dresp.data_ok = 1'b1;
                dresp.rdata   = ram[dreq.addr[7:2]];
            end else begin
                d_delay--;
            end
        end
    endtask

    initial begin
        rst       = 1'b1;
        iresp     = '0;
        dresp     = '0;
        i_busy    = 1'b0;
        d_busy    = 1'b0;
        i_delay   = 0;
        d_delay   = 0;
        cycle     = 0;
        n_commits = 0;
        finished  = 1'b0;
        void'($urandom(SEED));
        build_program();
        for (int i = 0; i < 64; i++) begin
            ram[i]   = ram_fill(i);
            m_ram[i] = ram_fill(i);
        end
        for (int i = 0; i < 32; i++) begin
            m_regs[i] = '0;
        end
        m_pc = RESET_PC;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        while (!finished) begin
            @(posedge clk);
            sample_outputs();
            @(negedge clk);
            drive_responses();
        end
        for (int i = 0; i < 64; i++) begin
            check_word($sformatf("final ram word %0d", i), m_ram[i], ram[i]);
        end
        if (i_dut.i_checker.errors != 0) begin
            fail_with("Error: an assertion on the bus handshake or retire port failed");
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire
